/* project.f */
verilog/bb_pkg.sv
verilog/bb_bit_if.sv
verilog/bb_lfsr.sv
verilog/tx_header_gen.sv
verilog/tx_payload_gen.sv
verilog/tx_bit_seq.sv
verilog/rx_header_dec.sv
verilog/bb_bit_proc.sv
verif/bb_bit_proc_assert.sv
verif/tb_bb_bit_proc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bb_bit_proc
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_bb_bit_proc.sv */
`timescale 1ns/1ps

module tb_bb_bit_proc;

  logic       clk_6M;
  logic       rst_n;
  logic       p_1us = 1'b0;
  logic       tx_start_p;
  logic [2:0] tx_lt_addr;
  logic [3:0] tx_pk_type;
  logic       tx_flow;
  logic       tx_arqn;
  logic       tx_seqn;
  logic [7:0] uap;
  logic [5:0] clk_bits;
  logic       whitening_en;
  logic [4:0] py_len;
  logic       wr_en;
  logic [3:0] wr_addr;
  logic [7:0] wr_data;
  logic       rx_en = 1'b0;
  logic       rxbit = 1'b0;
  logic [2:0] my_lt_addr;
  logic       txbit;
  logic       txbit_period;
  logic       tx_done_p;
  logic [2:0] dec_lt_addr;
  logic [3:0] dec_pk_type;
  logic       dec_flow;
  logic       dec_arqn;
  logic       dec_seqn;
  logic       dec_hecgood;
  logic       lt_addressed;
  logic       rxispoll;
  logic       rx_hdr_done_p;

  integer     seed;
  int         us_cnt = 0;
  logic       loop_en = 1'b0;
  logic       flip [0:255];
  logic       ref_bits [0:255];
  logic       alt_bits [0:255];
  logic       cap_bits [0:255];
  logic [7:0] py_bytes [0:15];
  int         cap_n = 0;
  int         pkt_errs = 0;
  int         done_cnt = 0;
  int         rx_done_cnt = 0;
  int         test_errs = 0;
  int         n_tests = 0;
  int         n_failed = 0;

  bb_bit_proc #(
    .PY_MAX_BYTES (16)
  ) bb_bit_proc_i (
    .*
  );

  initial begin
    clk_6M = 1'b0;
    forever #10 clk_6M = ~clk_6M;
  end

  // one p_1us strobe every 6 clocks
  always @(negedge clk_6M) begin
    if (!rst_n) begin
      us_cnt <= 0;
      p_1us  <= 1'b0;
    end else begin
      us_cnt <= (us_cnt == 5) ? 0 : us_cnt + 1;
      p_1us  <= us_cnt == 5;
    end
  end

  // cap_n indexes the bit now on air during loopback
  always @(negedge clk_6M) begin
    if (loop_en) begin
      rxbit <= txbit ^ (txbit_period & flip[cap_n]);
      rx_en <= txbit_period;
    end else begin
      rxbit <= 1'b0;
      rx_en <= 1'b0;
    end
  end

  // txbit still holds the previous bit time here
  always @(posedge clk_6M) begin
    if (tx_start_p && !txbit_period) begin
      cap_n       = 0;
      pkt_errs    = 0;
      done_cnt    = 0;
      rx_done_cnt = 0;
    end else begin
      if (p_1us && txbit_period && cap_n < 256) begin
        cap_bits[cap_n] = txbit;
        assert (txbit == ref_bits[cap_n]) else begin
          $display("mismatch txbit bit %0d got %h exp %h", cap_n, txbit, ref_bits[cap_n]);
          pkt_errs++;
        end
        cap_n++;
      end
      if (tx_done_p) done_cnt++;
      if (rx_hdr_done_p) rx_done_cnt++;
    end
  end

  // expected air stream with every header bit sent three times
  function automatic int ref_air_bits(input logic [9:0] hdr, input logic [7:0] uap_v,
                                      input logic [5:0] clk_v, input logic wh, input int len);
    logic [7:0]  hec;
    logic [15:0] crc;
    logic [6:0]  wr;
    logic        ib;
    logic        fb;
    int          n;
    hec = uap_v;
    crc = {uap_v, 8'h00};
    wr  = {1'b1, clk_v};
    n   = 0;
    for (int i = 0; i < 18; i++) begin
      if (i < 10) begin
        ib  = hdr[i];
        fb  = ib ^ hec[7];
        hec = {hec[6:0], 1'b0} ^ (fb ? 8'hA7 : 8'h00);
      end else begin
        ib  = hec[7];
        hec = {hec[6:0], 1'b0};
      end
      ib = ib ^ (wh & wr[6]);
      wr = {wr[5:0], 1'b0} ^ (wr[6] ? 7'h11 : 7'h00);
      for (int r = 0; r < 3; r++) begin
        ref_bits[n] = ib;
        n++;
      end
    end
    if (len > 0) begin
      for (int i = 0; i < len * 8 + 16; i++) begin
        if (i < len * 8) begin
          ib  = py_bytes[i / 8][i % 8];
          fb  = ib ^ crc[15];
          crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end else begin
          ib  = crc[15];
          crc = {crc[14:0], 1'b0};
        end
        ib = ib ^ (wh & wr[6]);
        wr = {wr[5:0], 1'b0} ^ (wr[6] ? 7'h11 : 7'h00);
        ref_bits[n] = ib;
        n++;
      end
    end
    return n;
  endfunction

  function automatic logic [9:0] tx_hdr_vec();
    return {tx_seqn, tx_arqn, tx_flow, tx_pk_type, tx_lt_addr};
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (test_errs == 0) begin
      $display("test %0d %s ok", n_tests, name);
    end else begin
      n_failed++;
      $display("test %0d %s failed with %0d errors", n_tests, name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic random_header(input logic [3:0] pk);
    tx_lt_addr = 3'($random(seed));
    tx_pk_type = pk;
    tx_flow    = 1'($random(seed));
    tx_arqn    = 1'($random(seed));
    tx_seqn    = 1'($random(seed));
    uap        = 8'($random(seed));
    clk_bits   = 6'($random(seed));
  endtask

  task automatic load_payload(input int len);
    for (int k = 0; k < len; k++) begin
      py_bytes[k] = 8'($random(seed));
      wr_en   = 1'b1;
      wr_addr = 4'(k);
      wr_data = py_bytes[k];
      @(negedge clk_6M);
    end
    wr_en = 1'b0;
  endtask

  task automatic send_pkt(input int len, input logic restart);
    int nbits;
    int t;
    py_len = 5'(len);
    nbits  = ref_air_bits(tx_hdr_vec(), uap, clk_bits, whitening_en, len);
    tx_start_p = 1'b1;
    @(negedge clk_6M);
    tx_start_p = 1'b0;
    if (restart) begin
      t = 0;
      while (cap_n < 20 && t < 2000) begin
        @(negedge clk_6M);
        t++;
      end
      if (cap_n < 20) begin
        $display("timeout waiting for 20 bits on air");
        test_errs++;
      end
      tx_start_p = 1'b1;
      @(negedge clk_6M);
      tx_start_p = 1'b0;
    end
    t = 0;
    while (!tx_done_p && t < 5000) begin
      @(negedge clk_6M);
      t++;
    end
    if (!tx_done_p) begin
      $display("timeout waiting for end of packet");
      test_errs++;
    end
    repeat (2) @(negedge clk_6M);
    check_val("air bit count", cap_n, nbits);
    check_val("tx_done_p pulses", done_cnt, 1);
    test_errs += pkt_errs;
  endtask

  task automatic check_rx(input logic exp_good, input logic exp_addr, input logic exp_poll);
    check_val("rx_hdr_done_p pulses", rx_done_cnt, 1);
    check_val("dec_hecgood", int'(dec_hecgood), int'(exp_good));
    check_val("lt_addressed", int'(lt_addressed), int'(exp_addr));
    check_val("rxispoll", int'(rxispoll), int'(exp_poll));
    if (exp_good) begin
      check_val("dec_lt_addr", int'(dec_lt_addr), int'(tx_lt_addr));
      check_val("dec_pk_type", int'(dec_pk_type), int'(tx_pk_type));
      check_val("dec_flow", int'(dec_flow), int'(tx_flow));
      check_val("dec_arqn", int'(dec_arqn), int'(tx_arqn));
      check_val("dec_seqn", int'(dec_seqn), int'(tx_seqn));
    end
  endtask

  initial begin
    int len;
    int diffs;
    int n_alt;
    seed         = 60;
    rst_n        = 1'b0;
    tx_start_p   = 1'b0;
    whitening_en = 1'b1;
    py_len       = '0;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    my_lt_addr   = '0;
    random_header(4'h0);
    for (int i = 0; i < 256; i++) begin
      flip[i] = 1'b0;
    end
    repeat (2) @(negedge clk_6M);
    rst_n = 1'b1;
    repeat (2) @(negedge clk_6M);

    random_header(4'h1);
    send_pkt(0, 1'b0);
    check_val("poll period bits", cap_n, 54);
    end_test("poll length 0");

    for (int p = 0; p < 4; p++) begin
      len = 1 + ({$random(seed)} % 16);
      random_header(4'($random(seed)));
      load_payload(len);
      send_pkt(len, 1'b0);
      check_val("period bits", cap_n, 54 + 8 * len + 16);
    end
    end_test("random payloads");

    // whitened stream kept aside for comparison
    random_header(4'h3);
    load_payload(5);
    n_alt = ref_air_bits(tx_hdr_vec(), uap, clk_bits, 1'b1, 5);
    for (int i = 0; i < n_alt; i++) begin
      alt_bits[i] = ref_bits[i];
    end
    whitening_en = 1'b0;
    send_pkt(5, 1'b0);
    diffs = 0;
    for (int i = 0; i < n_alt; i++) begin
      if (cap_bits[i] != alt_bits[i]) diffs++;
    end
    assert (diffs > 0) else begin
      $display("stream without whitening equals the whitened stream");
      test_errs++;
    end
    whitening_en = 1'b1;
    end_test("whitening off");

    loop_en = 1'b1;
    random_header(4'h1);
    my_lt_addr = tx_lt_addr;
    send_pkt(0, 1'b0);
    check_rx(1'b1, 1'b1, 1'b1);
    random_header(4'h0);
    my_lt_addr = tx_lt_addr;
    load_payload(2);
    send_pkt(2, 1'b0);
    check_rx(1'b1, 1'b1, 1'b0);
    random_header(4'h1);
    my_lt_addr = tx_lt_addr + 3'd1;
    send_pkt(0, 1'b0);
    check_rx(1'b1, 1'b0, 1'b0);
    end_test("loopback decode");

    // one bad copy per bit, first, second and third position
    random_header(4'h1);
    my_lt_addr = tx_lt_addr;
    flip[6]  = 1'b1;
    flip[10] = 1'b1;
    flip[14] = 1'b1;
    send_pkt(0, 1'b0);
    check_rx(1'b1, 1'b1, 1'b1);
    flip[6]  = 1'b0;
    flip[10] = 1'b0;
    flip[14] = 1'b0;
    flip[15] = 1'b1;
    flip[16] = 1'b1;
    flip[17] = 1'b1;
    send_pkt(0, 1'b0);
    check_rx(1'b0, 1'b0, 1'b0);
    flip[15] = 1'b0;
    flip[16] = 1'b0;
    flip[17] = 1'b0;
    loop_en  = 1'b0;
    end_test("header bit errors");

    random_header(4'h2);
    load_payload(3);
    send_pkt(3, 1'b1);
    check_val("period bits", cap_n, 54 + 8 * 3 + 16);
    end_test("start while busy");

    $display("tests run %0d, failed %0d", n_tests, n_failed);
    if (n_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verif/bb_bit_proc_assert.sv */
`timescale 1ns/1ps

module bb_bit_proc_assert (
  input logic clk_6M,
  input logic rst_n,
  input logic txbit,
  input logic txbit_period,
  input logic tx_done_p,
  input logic dec_hecgood,
  input logic lt_addressed
);

  // end of packet marks the drop of the period
  done_at_period_end: assert property (@(posedge clk_6M) disable iff (!rst_n)
    $rose(tx_done_p) |-> $fell(txbit_period))
    else $error("tx_done_p pulsed without txbit_period falling");

  quiet_outside_period: assert property (@(posedge clk_6M) disable iff (!rst_n)
    !txbit_period |-> !txbit)
    else $error("txbit high outside txbit_period");

  addressed_needs_hec: assert property (@(posedge clk_6M) disable iff (!rst_n)
    lt_addressed |-> dec_hecgood)
    else $error("lt_addressed set with a bad HEC");

endmodule

bind bb_bit_proc bb_bit_proc_assert bb_bit_proc_assert_u (.*);

/* verilog/bb_bit_proc.sv */
`timescale 1ns/1ps

module bb_bit_proc
  import bb_pkg::*;
#(
  parameter int PY_MAX_BYTES = 16
) (
  input  logic                              clk_6M,
  input  logic                              rst_n,
  input  logic                              p_1us,
  input  logic                              tx_start_p,
  input  lt_addr_t                          tx_lt_addr,
  input  pk_type_t                          tx_pk_type,
  input  logic                              tx_flow,
  input  logic                              tx_arqn,
  input  logic                              tx_seqn,
  input  logic [7:0]                        uap,
  input  logic [5:0]                        clk_bits,
  input  logic                              whitening_en,
  input  logic [$clog2(PY_MAX_BYTES+1)-1:0] py_len,
  input  logic                              wr_en,
  input  logic [$clog2(PY_MAX_BYTES)-1:0]   wr_addr,
  input  logic [7:0]                        wr_data,
  input  logic                              rx_en,
  input  logic                              rxbit,
  input  lt_addr_t                          my_lt_addr,
  output logic                              txbit,
  output logic                              txbit_period,
  output logic                              tx_done_p,
  output lt_addr_t                          dec_lt_addr,
  output pk_type_t                          dec_pk_type,
  output logic                              dec_flow,
  output logic                              dec_arqn,
  output logic                              dec_seqn,
  output logic                              dec_hecgood,
  output logic                              lt_addressed,
  output logic                              rxispoll,
  output logic                              rx_hdr_done_p
);

  bb_hdr_t tx_hdr;
  bb_hdr_t dec_hdr;

  bb_bit_if hdr_if ();
  bb_bit_if py_if ();

  assign tx_hdr = '{
    seqn:    tx_seqn,
    arqn:    tx_arqn,
    flow:    tx_flow,
    pk_type: tx_pk_type,
    lt_addr: tx_lt_addr
  };

  assign dec_lt_addr = dec_hdr.lt_addr;
  assign dec_pk_type = dec_hdr.pk_type;
  assign dec_flow    = dec_hdr.flow;
  assign dec_arqn    = dec_hdr.arqn;
  assign dec_seqn    = dec_hdr.seqn;

  tx_header_gen tx_header_gen_u (
    .clk_6M (clk_6M),
    .rst_n  (rst_n),
    .hdr    (tx_hdr),
    .uap    (uap),
    .hs     (hdr_if)
  );

  tx_payload_gen #(
    .PY_MAX_BYTES (PY_MAX_BYTES)
  ) tx_payload_gen_u (
    .clk_6M  (clk_6M),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .py_len  (py_len),
    .uap     (uap),
    .ps      (py_if)
  );

  tx_bit_seq #(
    .PY_MAX_BYTES (PY_MAX_BYTES)
  ) tx_bit_seq_u (
    .clk_6M       (clk_6M),
    .rst_n        (rst_n),
    .p_1us        (p_1us),
    .tx_start_p   (tx_start_p),
    .py_len       (py_len),
    .whitening_en (whitening_en),
    .clk_bits     (clk_bits),
    .hs           (hdr_if),
    .ps           (py_if),
    .txbit        (txbit),
    .txbit_period (txbit_period),
    .tx_done_p    (tx_done_p)
  );

  rx_header_dec rx_header_dec_u (
    .clk_6M        (clk_6M),
    .rst_n         (rst_n),
    .p_1us         (p_1us),
    .rx_en         (rx_en),
    .rxbit         (rxbit),
    .uap           (uap),
    .whitening_en  (whitening_en),
    .clk_bits      (clk_bits),
    .my_lt_addr    (my_lt_addr),
    .dec_hdr       (dec_hdr),
    .dec_hecgood   (dec_hecgood),
    .lt_addressed  (lt_addressed),
    .rxispoll      (rxispoll),
    .rx_hdr_done_p (rx_hdr_done_p)
  );

endmodule

/* verilog/rx_header_dec.sv */
`timescale 1ns/1ps

module rx_header_dec
  import bb_pkg::*;
(
  input  logic       clk_6M,
  input  logic       rst_n,
  input  logic       p_1us,
  input  logic       rx_en,
  input  logic       rxbit,
  input  logic [7:0] uap,
  input  logic       whitening_en,
  input  logic [5:0] clk_bits,
  input  lt_addr_t   my_lt_addr,
  output bb_hdr_t    dec_hdr,
  output logic       dec_hecgood,
  output logic       lt_addressed,
  output logic       rxispoll,
  output logic       rx_hdr_done_p
);

  logic                rx_en_d;
  logic                rise;
  logic                done;
  logic                done_eff;
  logic [1:0]          rep;
  logic [1:0]          rep_eff;
  logic [4:0]          nbit;
  logic [4:0]          nbit_eff;
  logic                samp;
  logic                third;
  logic                hdr_end;
  logic                s0;
  logic                s1;
  logic                maj;
  logic                wh_out;
  logic                dw;
  logic                hec_ok;
  logic                addr_ok;
  logic [HEC_BITS-1:0] hec_rx;
  logic [HEC_BITS-1:0] hec_calc;

  // a new rx_en window restarts counting in the same cycle
  assign rise     = rx_en & ~rx_en_d;
  assign rep_eff  = rise ? '0 : rep;
  assign nbit_eff = rise ? '0 : nbit;
  assign done_eff = rise ? 1'b0 : done;

  assign samp    = p_1us & rx_en & ~done_eff;
  assign third   = samp && rep_eff == 2'(FEC_REP - 1);
  assign hdr_end = third && nbit_eff == 5'(HDR_BITS + HEC_BITS - 1);

  // 2 of 3 vote, then de-whiten
  assign maj = (s0 & s1) | (s0 & rxbit) | (s1 & rxbit);
  assign dw  = maj ^ (whitening_en & wh_out);

  assign hec_ok  = {hec_rx[HEC_BITS-2:0], dw} == hec_calc;
  assign addr_ok = hec_ok && dec_hdr.lt_addr == my_lt_addr;

  bb_lfsr #(
    .WIDTH (7),
    .POLY  (WHITEN_POLY)
  ) whiten_u (
    .clk_6M  (clk_6M),
    .rst_n   (rst_n),
    .load    (rise),
    .seed    ({1'b1, clk_bits}),
    .shift   (third),
    .din     (1'b0),
    .feed_en (1'b1),
    .state   (),
    .dout    (wh_out)
  );

  bb_lfsr #(
    .WIDTH (HEC_BITS),
    .POLY  (HEC_POLY)
  ) hec_u (
    .clk_6M  (clk_6M),
    .rst_n   (rst_n),
    .load    (rise),
    .seed    (uap),
    .shift   (third && nbit_eff < 5'(HDR_BITS)),
    .din     (dw),
    .feed_en (1'b1),
    .state   (hec_calc),
    .dout    ()
  );

  always_ff @(posedge clk_6M) begin
    if (samp && rep_eff == 2'd0) begin
      s0 <= rxbit;
    end
    if (samp && rep_eff == 2'd1) begin
      s1 <= rxbit;
    end
    // first info bit ends up in bit 0
    if (third && nbit_eff < 5'(HDR_BITS)) begin
      dec_hdr <= bb_hdr_t'({dw, dec_hdr[HDR_BITS-1:1]});
    end
    if (third && nbit_eff >= 5'(HDR_BITS)) begin
      hec_rx <= {hec_rx[HEC_BITS-2:0], dw};
    end
  end

  always_ff @(posedge clk_6M or negedge rst_n) begin
    if (!rst_n) begin
      rx_en_d       <= 1'b0;
      rep           <= '0;
      nbit          <= '0;
      done          <= 1'b0;
      dec_hecgood   <= 1'b0;
      lt_addressed  <= 1'b0;
      rxispoll      <= 1'b0;
      rx_hdr_done_p <= 1'b0;
    end else begin
      rx_en_d       <= rx_en;
      rx_hdr_done_p <= hdr_end;
      if (rise) begin
        rep          <= '0;
        nbit         <= '0;
        done         <= 1'b0;
        dec_hecgood  <= 1'b0;
        lt_addressed <= 1'b0;
        rxispoll     <= 1'b0;
      end
      if (samp) begin
        rep <= third ? '0 : rep_eff + 1'b1;
        if (third) begin
          nbit <= nbit_eff + 1'b1;
        end
      end
      if (hdr_end) begin
        done         <= 1'b1;
        dec_hecgood  <= hec_ok;
        lt_addressed <= addr_ok;
        rxispoll     <= addr_ok && dec_hdr.pk_type == PK_POLL;
      end
    end
  end

endmodule

/* verilog/tx_bit_seq.sv */
`timescale 1ns/1ps

module tx_bit_seq
  import bb_pkg::*;
#(
  parameter int PY_MAX_BYTES = 16
) (
  input  logic                              clk_6M,
  input  logic                              rst_n,
  input  logic                              p_1us,
  input  logic                              tx_start_p,
  input  logic [$clog2(PY_MAX_BYTES+1)-1:0] py_len,
  input  logic                              whitening_en,
  input  logic [5:0]                        clk_bits,
  bb_bit_if.seq                             hs,
  bb_bit_if.seq                             ps,
  output logic                              txbit,
  output logic                              txbit_period,
  output logic                              tx_done_p
);

  typedef enum logic [1:0] {S_IDLE, S_HDR, S_PAY, S_TAIL} st_t;

  st_t        st;
  logic [1:0] rep;
  logic       has_py;
  logic       accept;
  logic       wh_out;
  logic       air_bit;

  assign accept   = tx_start_p && st == S_IDLE && !txbit_period;
  assign hs.start = accept;
  assign ps.start = accept;

  // header bit is held for all three copies, taken on the last
  assign hs.take = p_1us && st == S_HDR && rep == 2'(FEC_REP - 1);
  assign ps.take = p_1us && st == S_PAY;

  // whitener only advances on take, so the copies stay identical
  assign air_bit = (st == S_PAY ? ps.dbit : hs.dbit) ^ (whitening_en & wh_out);

  bb_lfsr #(
    .WIDTH (7),
    .POLY  (WHITEN_POLY)
  ) whiten_u (
    .clk_6M  (clk_6M),
    .rst_n   (rst_n),
    .load    (accept),
    .seed    ({1'b1, clk_bits}),
    .shift   (hs.take | ps.take),
    .din     (1'b0),
    .feed_en (1'b1),
    .state   (),
    .dout    (wh_out)
  );

  always_ff @(posedge clk_6M or negedge rst_n) begin
    if (!rst_n) begin
      st           <= S_IDLE;
      rep          <= '0;
      has_py       <= 1'b0;
      txbit        <= 1'b0;
      txbit_period <= 1'b0;
      tx_done_p    <= 1'b0;
    end else begin
      tx_done_p <= 1'b0;
      if (accept) begin
        st     <= S_HDR;
        rep    <= '0;
        has_py <= py_len != '0;
      end
      if (p_1us) begin
        case (st)
          S_HDR: begin
            txbit        <= air_bit;
            txbit_period <= 1'b1;
            if (hs.take) begin
              rep <= '0;
              if (hs.last) begin
                st <= has_py ? S_PAY : S_TAIL;
              end
            end else begin
              rep <= rep + 1'b1;
            end
          end
          S_PAY: begin
            txbit <= air_bit;
            if (ps.last) begin
              st <= S_TAIL;
            end
          end
          S_TAIL: begin
            // final bit has had its full bit time
            txbit        <= 1'b0;
            txbit_period <= 1'b0;
            tx_done_p    <= 1'b1;
            st           <= S_IDLE;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

/* verilog/tx_payload_gen.sv */
`timescale 1ns/1ps

module tx_payload_gen
  import bb_pkg::*;
#(
  parameter int PY_MAX_BYTES = 16
) (
  input  logic                                clk_6M,
  input  logic                                rst_n,
  input  logic                                wr_en,
  input  logic [$clog2(PY_MAX_BYTES)-1:0]     wr_addr,
  input  logic [7:0]                          wr_data,
  input  logic [$clog2(PY_MAX_BYTES+1)-1:0]   py_len,
  input  logic [7:0]                          uap,
  bb_bit_if.src                               ps
);

  localparam int AW = $clog2(PY_MAX_BYTES);
  localparam int LW = $clog2(PY_MAX_BYTES + 1);

  logic [7:0]    mem [PY_MAX_BYTES];
  logic [LW-1:0] len_q;
  logic [LW-1:0] byte_idx;
  logic [2:0]    bit_idx;
  logic [3:0]    crc_cnt;
  logic          in_crc;
  logic          data_bit;
  logic          crc_out;

  always_ff @(posedge clk_6M) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // lsb of each byte first
  assign data_bit = mem[byte_idx[AW-1:0]][bit_idx];

  assign ps.dbit = in_crc ? crc_out : data_bit;
  assign ps.last = in_crc && crc_cnt == 4'(CRC_BITS - 1);

  bb_lfsr #(
    .WIDTH (CRC_BITS),
    .POLY  (CRC_POLY)
  ) crc_u (
    .clk_6M  (clk_6M),
    .rst_n   (rst_n),
    .load    (ps.start),
    .seed    ({uap, 8'h00}),
    .shift   (ps.take),
    .din     (data_bit),
    .feed_en (!in_crc),
    .state   (),
    .dout    (crc_out)
  );

  always_ff @(posedge clk_6M or negedge rst_n) begin
    if (!rst_n) begin
      len_q    <= '0;
      byte_idx <= '0;
      bit_idx  <= '0;
      crc_cnt  <= '0;
      in_crc   <= 1'b0;
    end else if (ps.start) begin
      len_q    <= py_len;
      byte_idx <= '0;
      bit_idx  <= '0;
      crc_cnt  <= '0;
      in_crc   <= 1'b0;
    end else if (ps.take) begin
      if (in_crc) begin
        crc_cnt <= crc_cnt + 1'b1;
      end else begin
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == 3'd7) begin
          byte_idx <= byte_idx + 1'b1;
          // last data bit consumed, switch to the crc
          if (byte_idx == len_q - 1'b1) begin
            in_crc <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* verilog/tx_header_gen.sv */
`timescale 1ns/1ps

module tx_header_gen
  import bb_pkg::*;
(
  input  logic       clk_6M,
  input  logic       rst_n,
  input  bb_hdr_t    hdr,
  input  logic [7:0] uap,
  bb_bit_if.src      hs
);

  logic [HDR_BITS-1:0] hdr_q;
  logic [4:0]          cnt;
  logic                in_hdr;
  logic                hdr_bit;
  logic                hec_out;

  assign in_hdr  = cnt < 5'(HDR_BITS);
  assign hdr_bit = in_hdr ? hdr_q[cnt[3:0]] : 1'b0;

  // info bits first, then the hec remainder
  assign hs.dbit = in_hdr ? hdr_bit : hec_out;
  assign hs.last = cnt == 5'(HDR_BITS + HEC_BITS - 1);

  bb_lfsr #(
    .WIDTH (HEC_BITS),
    .POLY  (HEC_POLY)
  ) hec_u (
    .clk_6M  (clk_6M),
    .rst_n   (rst_n),
    .load    (hs.start),
    .seed    (uap),
    .shift   (hs.take),
    .din     (hdr_bit),
    .feed_en (in_hdr),
    .state   (),
    .dout    (hec_out)
  );

  always_ff @(posedge clk_6M) begin
    if (hs.start) begin
      hdr_q <= hdr;
    end
  end

  // bit position within the 18 bit header
  always_ff @(posedge clk_6M or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (hs.start) begin
      cnt <= '0;
    end else if (hs.take) begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* verilog/bb_lfsr.sv */
`timescale 1ns/1ps

module bb_lfsr #(
  parameter int              WIDTH = 8,
  parameter logic [WIDTH-1:0] POLY  = '0
) (
  input  logic             clk_6M,
  input  logic             rst_n,
  input  logic             load,
  input  logic [WIDTH-1:0] seed,
  input  logic             shift,
  input  logic             din,
  input  logic             feed_en,
  output logic [WIDTH-1:0] state,
  output logic             dout
);

  logic fb;

  assign dout = state[WIDTH-1];

  // zero feedback just drains the register top bit first
  assign fb = feed_en & (din ^ state[WIDTH-1]);

  always_ff @(posedge clk_6M or negedge rst_n) begin
    if (!rst_n) begin
      state <= '0;
    end else if (load) begin
      state <= seed;
    end else if (shift) begin
      state <= {state[WIDTH-2:0], 1'b0} ^ (fb ? POLY : '0);
    end
  end

endmodule

/* verilog/bb_bit_if.sv */
`timescale 1ns/1ps

// one serial bit source feeding the sequencer
interface bb_bit_if;
  logic dbit;
  logic take;
  logic start;
  logic last;

  modport src (
    output dbit, last,
    input  take, start
  );

  modport seq (
    input  dbit, last,
    output take, start
  );
endinterface

/* verilog/bb_pkg.sv */
package bb_pkg;

  // header fields
  typedef logic [2:0] lt_addr_t;
  typedef logic [3:0] pk_type_t;

  localparam pk_type_t PK_NULL = 4'h0;
  localparam pk_type_t PK_POLL = 4'h1;

  // lt_addr sits in the low bits so bit 0 goes on air first
  typedef struct packed {
    logic     seqn;
    logic     arqn;
    logic     flow;
    pk_type_t pk_type;
    lt_addr_t lt_addr;
  } bb_hdr_t;

  // packet lengths
  localparam int HDR_BITS     = 10;
  localparam int HEC_BITS     = 8;
  localparam int CRC_BITS     = 16;
  localparam int FEC_REP      = 3;
  localparam int HDR_AIR_BITS = (HDR_BITS + HEC_BITS) * FEC_REP;

  // D^8+D^7+D^5+D^2+D+1
  localparam logic [7:0] HEC_POLY = 8'hA7;

  // ccitt, x^16+x^12+x^5+1
  localparam logic [15:0] CRC_POLY = 16'h1021;

  // x^7+x^4+1
  localparam logic [6:0] WHITEN_POLY = 7'h11;

endpackage
